/* common/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Region codes in address bits 31:28
`define REGION_RAM 4'h1
`define REGION_DMA 4'h9
`define REGION_TIMER 4'hA

// Word offset carried to every slave, wide enough for the RAM
`define SOC_OFFSET_W 10
`define RAM_WORDS 1024

// Clocks per timer tick
`define TIMER_PRESCALE 4
`define SOC_LED_W 10

// DMA register offsets
`define DMA_REG_SRC 0
`define DMA_REG_DST 1
`define DMA_REG_COUNT 2
`define DMA_REG_CTRL 3

// Timer register offsets
`define TMR_REG_TIME_LO 0
`define TMR_REG_TIME_HI 1
`define TMR_REG_CMP_LO 2
`define TMR_REG_CMP_HI 3
`define TMR_REG_LED 4

`endif

/* common/soc_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

	// One bus word each
	typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
	typedef logic [`SOC_DATA_W-1:0] bus_data_t;

	// Region code from the top address nibble
	typedef logic [3:0] region_t;

	// Current bus owner
	typedef enum logic [1:0] {
		SEL_IBUS = 2'd0,
		SEL_DBUS = 2'd1,
		SEL_DMA  = 2'd2
	} master_sel_t;

	typedef enum logic [1:0] {
		DMA_IDLE  = 2'd0,
		DMA_READ  = 2'd1,
		DMA_WRITE = 2'd2
	} dma_state_t;

endpackage

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
	import soc_pkg::*;
(
	input  wire         i_rst_n,
	input  wire         clock,

	// Port A, instruction fetch, read only
	input  wire         i_pa_request,
	input  bus_addr_t   i_pa_address,
	output logic        o_pa_ready,
	output bus_data_t   o_pa_rdata,

	// Port B, data access
	input  wire         i_pb_request,
	input  wire         i_pb_rw,
	input  bus_addr_t   i_pb_address,
	input  bus_data_t   i_pb_wdata,
	output logic        o_pb_ready,
	output bus_data_t   o_pb_rdata,

	// Port C, DMA
	input  wire         i_pc_request,
	input  wire         i_pc_rw,
	input  bus_addr_t   i_pc_address,
	input  bus_data_t   i_pc_wdata,
	output logic        o_pc_ready,
	output bus_data_t   o_pc_rdata,

	// Shared bus
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output bus_addr_t   o_bus_address,
	output bus_data_t   o_bus_wdata,
	input  wire         i_bus_ready,
	input  bus_data_t   i_bus_rdata
);

	master_sel_t grant_q;
	master_sel_t grant_next;
	logic        any_request;

	// Fixed priority, data first, then DMA, then instruction
	always_comb
	begin
		any_request = i_pa_request | i_pb_request | i_pc_request;
		if (i_pb_request)
			grant_next = SEL_DBUS;
		else if (i_pc_request)
			grant_next = SEL_DMA;
		else
			grant_next = SEL_IBUS;
	end

	// Grant only from idle, so every access is followed by one free cycle
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_bus_request <= 1'b0;
			grant_q <= SEL_IBUS;
		end
		else if (o_bus_request)
		begin
			if (i_bus_ready)
				o_bus_request <= 1'b0;
		end
		else if (any_request)
		begin
			o_bus_request <= 1'b1;
			grant_q <= grant_next;
		end
	end

	// Bus fields, captured together with the grant and held until ready
	always_ff @(posedge clock)
	begin
		if (!o_bus_request && any_request)
		begin
			case (grant_next)
				SEL_DBUS:
				begin
					o_bus_rw <= i_pb_rw;
					o_bus_address <= i_pb_address;
					o_bus_wdata <= i_pb_wdata;
				end
				SEL_DMA:
				begin
					o_bus_rw <= i_pc_rw;
					o_bus_address <= i_pc_address;
					o_bus_wdata <= i_pc_wdata;
				end
				default:
				begin
					o_bus_rw <= 1'b0;
					o_bus_address <= i_pa_address;
					o_bus_wdata <= '0;
				end
			endcase
		end
	end

	// Ready goes only to the owner, rdata is shared
	assign o_pa_ready = o_bus_request && (grant_q == SEL_IBUS) && i_bus_ready;
	assign o_pb_ready = o_bus_request && (grant_q == SEL_DBUS) && i_bus_ready;
	assign o_pc_ready = o_bus_request && (grant_q == SEL_DMA) && i_bus_ready;

	assign o_pa_rdata = i_bus_rdata;
	assign o_pb_rdata = i_bus_rdata;
	assign o_pc_rdata = i_bus_rdata;

endmodule

`default_nettype wire

/* hw/addr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module addr_decoder
	import soc_pkg::*;
(
	input  wire                       i_rst_n,
	input  wire                       clock,
	input  wire                       i_bus_request,
	input  bus_addr_t                 i_bus_address,
	output bus_data_t                 o_bus_rdata,
	output logic                      o_bus_ready,

	output logic                      o_ram_request,
	input  bus_data_t                 i_ram_rdata,
	input  wire                       i_ram_ready,

	output logic                      o_dma_request,
	input  bus_data_t                 i_dma_rdata,
	input  wire                       i_dma_ready,

	output logic                      o_timer_request,
	input  bus_data_t                 i_timer_rdata,
	input  wire                       i_timer_ready,

	output logic [`SOC_OFFSET_W-1:0]  o_offset
);

	region_t region;
	logic    ram_sel;
	logic    dma_sel;
	logic    timer_sel;
	logic    unmapped_ready;

	assign region = i_bus_address[`SOC_ADDR_W-1 -: 4];
	assign ram_sel = (region == `REGION_RAM);
	assign dma_sel = (region == `REGION_DMA);
	assign timer_sel = (region == `REGION_TIMER);

	assign o_ram_request = i_bus_request && ram_sel;
	assign o_dma_request = i_bus_request && dma_sel;
	assign o_timer_request = i_bus_request && timer_sel;

	// Byte address to word offset
	assign o_offset = i_bus_address[`SOC_OFFSET_W+1:2];

	// Nobody home, complete after one cycle so the bus never hangs
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= i_bus_request && !(ram_sel || dma_sel || timer_sel)
				&& !unmapped_ready;
	end

	always_comb
	begin
		if (ram_sel)
		begin
			o_bus_rdata = i_ram_rdata;
			o_bus_ready = i_ram_ready;
		end
		else if (dma_sel)
		begin
			o_bus_rdata = i_dma_rdata;
			o_bus_ready = i_dma_ready;
		end
		else if (timer_sel)
		begin
			o_bus_rdata = i_timer_rdata;
			o_bus_ready = i_timer_ready;
		end
		else
		begin
			o_bus_rdata = '0;
			o_bus_ready = unmapped_ready;
		end
	end

endmodule

`default_nettype wire

/* hw/block_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module block_ram
	import soc_pkg::*;
(
	input  wire                       clock,
	input  wire                       i_request,
	input  wire                       i_rw,
	input  wire [`SOC_OFFSET_W-1:0]   i_offset,
	input  bus_data_t                 i_wdata,
	output bus_data_t                 o_rdata,
	output logic                      o_ready
);

	bus_data_t mem [`RAM_WORDS];

	// Request stays high through the ready cycle, so act once per access
	always_ff @(posedge clock)
	begin
		o_ready <= i_request && !o_ready;
	end

	always_ff @(posedge clock)
	begin
		if (i_request && !o_ready)
		begin
			if (i_rw)
				mem[i_offset] <= i_wdata;
			o_rdata <= mem[i_offset];
		end
	end

endmodule

`default_nettype wire

/* hw/sys_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module sys_timer
	import soc_pkg::*;
(
	input  wire                       i_rst_n,
	input  wire                       clock,
	input  wire                       i_request,
	input  wire                       i_rw,
	input  wire [`SOC_OFFSET_W-1:0]   i_offset,
	input  bus_data_t                 i_wdata,
	output bus_data_t                 o_rdata,
	output logic                      o_ready,
	output logic                      o_timer_irq,
	output logic [`SOC_LED_W-1:0]     o_leds
);

	localparam int unsigned PRESCALE_W = $clog2(`TIMER_PRESCALE);
	localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`TIMER_PRESCALE - 1);

	logic [PRESCALE_W-1:0] prescale_q;
	logic [63:0]           time_q;
	logic [63:0]           compare_q;
	logic                  access;
	bus_data_t             read_word;

	assign access = i_request && !o_ready;

	//======================================================================
	// Tick counter
	//======================================================================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			prescale_q <= '0;
			time_q <= '0;
		end
		else if (prescale_q == PRESCALE_LAST)
		begin
			prescale_q <= '0;
			time_q <= time_q + 64'd1;
		end
		else
			prescale_q <= prescale_q + 1'b1;
	end

	// Compare resets to all ones, so no interrupt out of reset
	assign o_timer_irq = (time_q >= compare_q);

	//======================================================================
	// Register port
	//======================================================================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			compare_q <= '1;
			o_leds <= '0;
			o_ready <= 1'b0;
		end
		else
		begin
			o_ready <= access;
			if (access && i_rw)
			begin
				case (i_offset)
					`TMR_REG_CMP_LO: compare_q[31:0] <= i_wdata;
					`TMR_REG_CMP_HI: compare_q[63:32] <= i_wdata;
					`TMR_REG_LED:    o_leds <= i_wdata[`SOC_LED_W-1:0];
					default:         ;
				endcase
			end
		end
	end

	always_comb
	begin
		case (i_offset)
			`TMR_REG_TIME_LO: read_word = time_q[31:0];
			`TMR_REG_TIME_HI: read_word = time_q[63:32];
			`TMR_REG_CMP_LO:  read_word = compare_q[31:0];
			`TMR_REG_CMP_HI:  read_word = compare_q[63:32];
			`TMR_REG_LED:     read_word = {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, o_leds};
			default:          read_word = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (access)
			o_rdata <= read_word;
	end

endmodule

`default_nettype wire

/* dma/dma_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module dma_engine
	import soc_pkg::*;
(
	input  wire                       i_rst_n,
	input  wire                       clock,

	// Register port
	input  wire                       i_request,
	input  wire                       i_rw,
	input  wire [`SOC_OFFSET_W-1:0]   i_offset,
	input  bus_data_t                 i_wdata,
	output bus_data_t                 o_rdata,
	output logic                      o_ready,

	// Bus master port
	output logic                      o_bus_request,
	output logic                      o_bus_rw,
	output bus_addr_t                 o_bus_address,
	output bus_data_t                 o_bus_wdata,
	input  wire                       i_bus_ready,
	input  bus_data_t                 i_bus_rdata
);

	dma_state_t state_q;
	bus_addr_t  src_q;
	bus_addr_t  dst_q;
	bus_data_t  count_q;
	bus_data_t  index_q;
	bus_data_t  index_next;
	bus_data_t  data_q;
	logic       busy;
	logic       access;
	bus_data_t  read_word;

	assign busy = (state_q != DMA_IDLE);
	assign access = i_request && !o_ready;
	assign index_next = index_q + 32'd1;

	//======================================================================
	// Register port
	//======================================================================

	// Setup and control writes are dropped while a copy runs
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			src_q <= '0;
			dst_q <= '0;
			count_q <= '0;
			o_ready <= 1'b0;
		end
		else
		begin
			o_ready <= access;
			if (access && i_rw && !busy)
			begin
				case (i_offset)
					`DMA_REG_SRC:   src_q <= i_wdata;
					`DMA_REG_DST:   dst_q <= i_wdata;
					`DMA_REG_COUNT: count_q <= i_wdata;
					default:        ;
				endcase
			end
		end
	end

	always_comb
	begin
		case (i_offset)
			`DMA_REG_SRC:   read_word = src_q;
			`DMA_REG_DST:   read_word = dst_q;
			`DMA_REG_COUNT: read_word = count_q;
			`DMA_REG_CTRL:  read_word = {{(`SOC_DATA_W-1){1'b0}}, busy};
			default:        read_word = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (access)
			o_rdata <= read_word;
	end

	//======================================================================
	// Copy FSM
	//======================================================================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state_q <= DMA_IDLE;
			index_q <= '0;
		end
		else
		begin
			case (state_q)
				DMA_IDLE:
				begin
					// Zero count finishes at once
					if (access && i_rw && (i_offset == `DMA_REG_CTRL) && (count_q != '0))
					begin
						index_q <= '0;
						state_q <= DMA_READ;
					end
				end
				DMA_READ:
				begin
					if (i_bus_ready)
						state_q <= DMA_WRITE;
				end
				DMA_WRITE:
				begin
					if (i_bus_ready)
					begin
						index_q <= index_next;
						state_q <= (index_next == count_q) ? DMA_IDLE : DMA_READ;
					end
				end
				default:
					state_q <= DMA_IDLE;
			endcase
		end
	end

	// Word in flight
	always_ff @(posedge clock)
	begin
		if (state_q == DMA_READ && i_bus_ready)
			data_q <= i_bus_rdata;
	end

	assign o_bus_request = busy;
	assign o_bus_rw = (state_q == DMA_WRITE);
	assign o_bus_address = (state_q == DMA_WRITE) ? dst_q + (index_q << 2) : src_q + (index_q << 2);
	assign o_bus_wdata = data_q;

endmodule

`default_nettype wire

/* hw/soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module soc_top
	import soc_pkg::*;
(
	input  wire                       i_rst_n,
	input  wire                       clock,

	// Instruction port
	input  wire                       i_ibus_request,
	input  bus_addr_t                 i_ibus_address,
	output logic                      o_ibus_ready,
	output bus_data_t                 o_ibus_rdata,

	// Data port
	input  wire                       i_dbus_request,
	input  wire                       i_dbus_rw,
	input  bus_addr_t                 i_dbus_address,
	input  bus_data_t                 i_dbus_wdata,
	output logic                      o_dbus_ready,
	output bus_data_t                 o_dbus_rdata,

	output logic                      o_timer_irq,
	output logic [`SOC_LED_W-1:0]     o_leds
);

	// Shared bus
	logic                     bus_request;
	logic                     bus_rw;
	bus_addr_t                bus_address;
	bus_data_t                bus_wdata;
	bus_data_t                bus_rdata;
	logic                     bus_ready;
	logic [`SOC_OFFSET_W-1:0] bus_offset;

	// DMA master side
	logic                     dma_bus_request;
	logic                     dma_bus_rw;
	bus_addr_t                dma_bus_address;
	bus_data_t                dma_bus_wdata;
	bus_data_t                dma_bus_rdata;
	logic                     dma_bus_ready;

	// Slave side
	logic                     ram_request;
	bus_data_t                ram_rdata;
	logic                     ram_ready;
	logic                     dma_request;
	bus_data_t                dma_rdata;
	logic                     dma_ready;
	logic                     timer_request;
	bus_data_t                timer_rdata;
	logic                     timer_ready;

	//======================================================================
	// Masters onto the shared bus
	//======================================================================

	bus_arbiter u_arbiter (
		.i_rst_n(i_rst_n),
		.clock(clock),
		.i_pa_request(i_ibus_request),
		.i_pa_address(i_ibus_address),
		.o_pa_ready(o_ibus_ready),
		.o_pa_rdata(o_ibus_rdata),
		.i_pb_request(i_dbus_request),
		.i_pb_rw(i_dbus_rw),
		.i_pb_address(i_dbus_address),
		.i_pb_wdata(i_dbus_wdata),
		.o_pb_ready(o_dbus_ready),
		.o_pb_rdata(o_dbus_rdata),
		.i_pc_request(dma_bus_request),
		.i_pc_rw(dma_bus_rw),
		.i_pc_address(dma_bus_address),
		.i_pc_wdata(dma_bus_wdata),
		.o_pc_ready(dma_bus_ready),
		.o_pc_rdata(dma_bus_rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	addr_decoder u_decoder (
		.i_rst_n(i_rst_n),
		.clock(clock),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_bus_rdata(bus_rdata),
		.o_bus_ready(bus_ready),
		.o_ram_request(ram_request),
		.i_ram_rdata(ram_rdata),
		.i_ram_ready(ram_ready),
		.o_dma_request(dma_request),
		.i_dma_rdata(dma_rdata),
		.i_dma_ready(dma_ready),
		.o_timer_request(timer_request),
		.i_timer_rdata(timer_rdata),
		.i_timer_ready(timer_ready),
		.o_offset(bus_offset)
	);

	//======================================================================
	// Slaves
	//======================================================================

	block_ram u_ram (
		.clock(clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_offset(bus_offset),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	sys_timer u_timer (
		.i_rst_n(i_rst_n),
		.clock(clock),
		.i_request(timer_request),
		.i_rw(bus_rw),
		.i_offset(bus_offset),
		.i_wdata(bus_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_timer_irq(o_timer_irq),
		.o_leds(o_leds)
	);

	// Slave on the register side, master on port C
	dma_engine u_dma (
		.i_rst_n(i_rst_n),
		.clock(clock),
		.i_request(dma_request),
		.i_rw(bus_rw),
		.i_offset(bus_offset),
		.i_wdata(bus_wdata),
		.o_rdata(dma_rdata),
		.o_ready(dma_ready),
		.o_bus_request(dma_bus_request),
		.o_bus_rw(dma_bus_rw),
		.o_bus_address(dma_bus_address),
		.o_bus_wdata(dma_bus_wdata),
		.i_bus_ready(dma_bus_ready),
		.i_bus_rdata(dma_bus_rdata)
	);

endmodule

`default_nettype wire

/* tb/tb_soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module tb_soc_top
	import soc_pkg::*;
();

	localparam int CLOCK_PERIOD = 10;
	localparam int NUM_WORDS = 16;
	localparam int DMA_WORDS = 16;
	localparam int CONC_READS = 8;
	localparam int DMA_SRC_OFF = 512;
	localparam int DMA_DST_OFF = 768;
	localparam int IRQ_DELTA = 20;
	localparam int IRQ_LIMIT = IRQ_DELTA * `TIMER_PRESCALE + 16;
	// Three bus cycles per access, the instruction port may sit out a whole copy
	localparam int WAIT_LIMIT = (2 * DMA_WORDS + CONC_READS) * 3 * 2;
	localparam int ACCESS_CYCLES = 8;
	localparam int EST_ACCESSES = 3 * NUM_WORDS + 5 * DMA_WORDS + 2 * CONC_READS + 16;
	localparam int TEST_CYCLES = EST_ACCESSES * ACCESS_CYCLES + IRQ_LIMIT + 20;
	localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLOCK_PERIOD;

	logic                  clock;
	logic                  rst_n;
	logic                  ibus_request;
	bus_addr_t             ibus_address;
	logic                  ibus_ready;
	bus_data_t             ibus_rdata;
	logic                  dbus_request;
	logic                  dbus_rw;
	bus_addr_t             dbus_address;
	bus_data_t             dbus_wdata;
	logic                  dbus_ready;
	bus_data_t             dbus_rdata;
	logic                  timer_irq;
	logic [`SOC_LED_W-1:0] leds;

	// Expected values and check enables
	bus_data_t             ram_model [`RAM_WORDS];
	int unsigned           word_offs [2 * NUM_WORDS];
	logic                  dbus_check = 1'b0;
	bus_data_t             dbus_expect = '0;
	logic                  ibus_check = 1'b0;
	bus_data_t             ibus_expect = '0;
	logic                  irq_low_expected = 1'b1;
	logic                  irq_waiting = 1'b0;
	logic                  led_check = 1'b0;
	logic [`SOC_LED_W-1:0] led_expect = '0;
	int                    irq_wait_cycles = 0;
	int                    dbus_wait_cycles = 0;
	int                    ibus_wait_cycles = 0;

	soc_top dut0 (
		.i_rst_n(rst_n),
		.clock(clock),
		.i_ibus_request(ibus_request),
		.i_ibus_address(ibus_address),
		.o_ibus_ready(ibus_ready),
		.o_ibus_rdata(ibus_rdata),
		.i_dbus_request(dbus_request),
		.i_dbus_rw(dbus_rw),
		.i_dbus_address(dbus_address),
		.i_dbus_wdata(dbus_wdata),
		.o_dbus_ready(dbus_ready),
		.o_dbus_rdata(dbus_rdata),
		.o_timer_irq(timer_irq),
		.o_leds(leds)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	function automatic bus_addr_t region_addr(input region_t region, input int unsigned word);
		return {region, 28'h0} + bus_addr_t'(word * 4);
	endfunction

	//======================================================================
	// Bus master tasks
	//======================================================================

	task automatic data_access(input logic rw, input bus_addr_t addr, input bus_data_t wdata,
		input logic check, input bus_data_t expected, output bus_data_t rdata);
		@(posedge clock);
		dbus_check = check && !rw;
		dbus_expect = expected;
		dbus_request <= 1'b1;
		dbus_rw <= rw;
		dbus_address <= addr;
		dbus_wdata <= wdata;
		@(negedge clock);
		while (!dbus_ready)
			@(negedge clock);
		rdata = dbus_rdata;
		@(posedge clock);
		dbus_request <= 1'b0;
		dbus_check = 1'b0;
	endtask

	task automatic data_write(input bus_addr_t addr, input bus_data_t wdata);
		bus_data_t unused;
		data_access(1'b1, addr, wdata, 1'b0, '0, unused);
	endtask

	task automatic data_check(input bus_addr_t addr, input bus_data_t expected);
		bus_data_t unused;
		data_access(1'b0, addr, '0, 1'b1, expected, unused);
	endtask

	task automatic data_poll(input bus_addr_t addr, output bus_data_t rdata);
		data_access(1'b0, addr, '0, 1'b0, '0, rdata);
	endtask

	task automatic fetch_check(input bus_addr_t addr, input bus_data_t expected);
		@(posedge clock);
		ibus_expect = expected;
		ibus_check = 1'b1;
		ibus_request <= 1'b1;
		ibus_address <= addr;
		@(negedge clock);
		while (!ibus_ready)
			@(negedge clock);
		@(posedge clock);
		ibus_request <= 1'b0;
		ibus_check = 1'b0;
	endtask

	//======================================================================
	// Checks
	//======================================================================

	// Counters move on the falling edge, away from the stimulus
	always @(negedge clock)
	begin
		irq_wait_cycles <= (irq_waiting && !timer_irq) ? irq_wait_cycles + 1 : 0;
		dbus_wait_cycles <= (dbus_request && !dbus_ready) ? dbus_wait_cycles + 1 : 0;
		ibus_wait_cycles <= (ibus_request && !ibus_ready) ? ibus_wait_cycles + 1 : 0;
	end

	dbus_rdata_ok: assert property (@(posedge clock) disable iff (!rst_n)
		(dbus_ready && dbus_check) |-> (dbus_rdata == dbus_expect))
		else stop_run($sformatf("CHECK FAILED at %0t: data port read 0x%08h, expected 0x%08h",
			$time, $sampled(dbus_rdata), $sampled(dbus_expect)));

	ibus_rdata_ok: assert property (@(posedge clock) disable iff (!rst_n)
		(ibus_ready && ibus_check) |-> (ibus_rdata == ibus_expect))
		else stop_run($sformatf("CHECK FAILED at %0t: fetch read 0x%08h, expected 0x%08h",
			$time, $sampled(ibus_rdata), $sampled(ibus_expect)));

	irq_low_ok: assert property (@(posedge clock) disable iff (!rst_n)
		irq_low_expected |-> !timer_irq)
		else stop_run($sformatf("CHECK FAILED at %0t: timer interrupt high, expected low", $time));

	irq_rise_ok: assert property (@(posedge clock) disable iff (!rst_n)
		irq_wait_cycles <= IRQ_LIMIT)
		else stop_run($sformatf("CHECK FAILED at %0t: timer interrupt not raised in %0d cycles",
			$time, IRQ_LIMIT));

	leds_ok: assert property (@(posedge clock) disable iff (!rst_n)
		led_check |-> (leds == led_expect))
		else stop_run($sformatf("CHECK FAILED at %0t: leds 0x%03h, expected 0x%03h",
			$time, $sampled(leds), $sampled(led_expect)));

	dbus_wait_ok: assert property (@(posedge clock) disable iff (!rst_n)
		dbus_wait_cycles < WAIT_LIMIT)
		else stop_run($sformatf("Data port waited more than %0d cycles for ready", WAIT_LIMIT));

	ibus_wait_ok: assert property (@(posedge clock) disable iff (!rst_n)
		ibus_wait_cycles < WAIT_LIMIT)
		else stop_run($sformatf("Fetch port waited more than %0d cycles for ready", WAIT_LIMIT));

	dbus_ready_ok: assert property (@(posedge clock) disable iff (!rst_n)
		dbus_ready |-> dbus_request)
		else stop_run("Data port ready came without a request");

	ibus_ready_ok: assert property (@(posedge clock) disable iff (!rst_n)
		ibus_ready |-> ibus_request)
		else stop_run("Fetch port ready came without a request");

	initial
	begin
		#(WATCHDOG_NS);
		stop_run("Watchdog timeout, the tests did not finish in time");
	end

	//======================================================================
	// Stimulus
	//======================================================================

	initial
	begin
		int          i;
		int          j;
		bus_data_t   value;
		bus_data_t   time_lo;
		bus_data_t   time_hi;
		logic [63:0] cmp;

		void'($urandom(32'hd7b3));
		rst_n = 1'b0;
		ibus_request = 1'b0;
		ibus_address = '0;
		dbus_request = 1'b0;
		dbus_rw = 1'b0;
		dbus_address = '0;
		dbus_wdata = '0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;

		// RAM through both ports
		for (i = 0; i < 2 * NUM_WORDS; i++)
		begin
			word_offs[i] = $urandom_range(255, 0);
			value = $urandom();
			ram_model[word_offs[i]] = value;
			data_write(region_addr(`REGION_RAM, word_offs[i]), value);
		end
		for (i = 0; i < 2 * NUM_WORDS; i++)
			data_check(region_addr(`REGION_RAM, word_offs[i]), ram_model[word_offs[i]]);
		for (i = 0; i < NUM_WORDS; i++)
			fetch_check(region_addr(`REGION_RAM, word_offs[i]), ram_model[word_offs[i]]);

		// Region 5 has no slave
		data_check(32'h5000_0010, 32'h0);

		// Timer compare interrupt
		data_poll(region_addr(`REGION_TIMER, `TMR_REG_TIME_LO), time_lo);
		data_poll(region_addr(`REGION_TIMER, `TMR_REG_TIME_HI), time_hi);
		cmp = {time_hi, time_lo} + 64'(IRQ_DELTA);
		data_write(region_addr(`REGION_TIMER, `TMR_REG_CMP_LO), cmp[31:0]);
		irq_low_expected = 1'b0;
		data_write(region_addr(`REGION_TIMER, `TMR_REG_CMP_HI), cmp[63:32]);
		irq_waiting = 1'b1;
		while (!timer_irq)
			@(negedge clock);
		irq_waiting = 1'b0;
		data_write(region_addr(`REGION_TIMER, `TMR_REG_CMP_HI), 32'hffff_ffff);
		irq_low_expected = 1'b1;
		data_check(region_addr(`REGION_TIMER, `TMR_REG_CMP_HI), 32'hffff_ffff);

		// LED register
		value = $urandom();
		data_write(region_addr(`REGION_TIMER, `TMR_REG_LED), value);
		led_expect = value[`SOC_LED_W-1:0];
		led_check = 1'b1;
		data_check(region_addr(`REGION_TIMER, `TMR_REG_LED),
			{{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, value[`SOC_LED_W-1:0]});

		// DMA copy with both CPU ports busy at the same time
		for (i = 0; i < DMA_WORDS; i++)
		begin
			value = $urandom();
			ram_model[DMA_SRC_OFF + i] = value;
			data_write(region_addr(`REGION_RAM, DMA_SRC_OFF + i), value);
		end
		data_write(region_addr(`REGION_DMA, `DMA_REG_SRC), region_addr(`REGION_RAM, DMA_SRC_OFF));
		data_write(region_addr(`REGION_DMA, `DMA_REG_DST), region_addr(`REGION_RAM, DMA_DST_OFF));
		data_write(region_addr(`REGION_DMA, `DMA_REG_COUNT), DMA_WORDS);
		data_write(region_addr(`REGION_DMA, `DMA_REG_CTRL), 32'h1);
		fork
			begin
				for (i = 0; i < CONC_READS; i++)
					data_check(region_addr(`REGION_RAM, word_offs[i]), ram_model[word_offs[i]]);
			end
			begin
				for (j = 0; j < CONC_READS; j++)
					fetch_check(region_addr(`REGION_RAM, word_offs[NUM_WORDS + j]),
						ram_model[word_offs[NUM_WORDS + j]]);
			end
		join
		do
			data_poll(region_addr(`REGION_DMA, `DMA_REG_CTRL), value);
		while (value[0]);
		for (i = 0; i < DMA_WORDS; i++)
		begin
			ram_model[DMA_DST_OFF + i] = ram_model[DMA_SRC_OFF + i];
			data_check(region_addr(`REGION_RAM, DMA_DST_OFF + i), ram_model[DMA_DST_OFF + i]);
		end

		repeat (4) @(posedge clock);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* soc_top.f */
+incdir+common
common/soc_pkg.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/block_ram.sv
hw/sys_timer.sv
dma/dma_engine.sv
hw/soc_top.sv
tb/tb_soc_top.sv
